// File: source/roce_hdr_pkg.sv
package roce_hdr_pkg;

  // packet sizes in bytes
  localparam int BEAT_BYTES            = 64;
  localparam int HDR_BYTES             = 58;
  localparam int RD_RESP_PAYLOAD_BYTES = 256;
  localparam int RD_RESP_BYTES         = HDR_BYTES + RD_RESP_PAYLOAD_BYTES;

  localparam int LEN_W      = $clog2(RD_RESP_BYTES + 1);
  localparam int BEAT_IDX_W = $clog2((RD_RESP_BYTES + BEAT_BYTES - 1) / BEAT_BYTES);

  localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
  localparam logic [7:0]  IP_VER_IHL     = 8'h45;
  localparam logic [7:0]  IP_TOS         = 8'hb8;
  localparam logic [15:0] IP_ID          = 16'h5555;
  localparam logic [15:0] IP_FLAGS       = 16'h4000; // don't fragment
  localparam logic [7:0]  IP_TTL         = 8'hba;
  localparam logic [7:0]  IP_PROTO_UDP   = 8'h11;
  localparam logic [15:0] UDP_SRC_PORT   = 16'h6851;
  localparam logic [15:0] UDP_DST_PORT   = 16'h12b7; // RoCEv2 port 4791
  localparam logic [15:0] BTH_PKEY       = 16'h666f;

  localparam logic [15:0] IP_TOTAL_LEN_RD  = 16'h0130;
  localparam logic [15:0] IP_TOTAL_LEN_ACK = 16'h0030;
  localparam logic [15:0] UDP_LEN_RD       = IP_TOTAL_LEN_RD - 16'h0014;
  localparam logic [15:0] UDP_LEN_ACK      = IP_TOTAL_LEN_ACK - 16'h0014;

  // route table covers QPs 2..7
  localparam int QP_FIRST = 2;
  localparam int QP_COUNT = 6;

  typedef enum logic [7:0] {
    OP_RD_RESP_ONLY = 8'h10,
    OP_ACK          = 8'h11
  } bth_opcode_e;

  typedef struct packed {
    logic [47:0] dst_mac;
    logic [31:0] dst_ip;
  } qp_route_t;

  typedef struct packed {
    logic [47:0]                 src_mac;
    logic [31:0]                 src_ip;
    qp_route_t [QP_COUNT-1:0]    route;
  } net_cfg_t;

  // index 0 is the first byte on the wire
  typedef logic [HDR_BYTES-1:0][7:0] roce_hdr_t;

endpackage

// File: source/resp_ctrl_pkg.sv
package resp_ctrl_pkg;

  localparam int NUM_PKTS_PER_PHASE = 8;
  localparam int GAP_CYCLES         = 256;

  localparam int PKT_CNT_W = $clog2(NUM_PKTS_PER_PHASE + 1);
  localparam int GAP_CNT_W = $clog2(GAP_CYCLES);

  typedef enum logic [1:0] {
    PH_IDLE,
    PH_RD_RESP,
    PH_ACK,
    PH_DONE
  } phase_e;

  typedef enum logic [2:0] {
    S_WAIT_CONF,
    S_POST,
    S_WAIT_REQ,
    S_SEND,
    S_GAP
  } seq_state_e;

  // beat from the work-request processor
  typedef struct packed {
    logic [roce_hdr_pkg::BEAT_BYTES*8-1:0] data;
    logic                                  valid;
    logic                                  last;
  } wqe_beat_t;

  typedef struct packed {
    logic [23:0] qp_num;
    logic [23:0] psn;
  } rd_req_t;

  typedef struct packed {
    logic [roce_hdr_pkg::BEAT_BYTES*8-1:0] data;
    logic [roce_hdr_pkg::BEAT_BYTES-1:0]   keep;
    logic                                  valid;
    logic                                  last;
  } tx_beat_t;

endpackage

// File: source/wqe_req_decode.sv
module wqe_req_decode (
  input  logic                     core_clk,
  input  logic                     core_aresetn,
  input  resp_ctrl_pkg::wqe_beat_t wqe_i,
  output resp_ctrl_pkg::rd_req_t   req_o,
  output logic                     req_valid_o
);

  logic in_pkt; // first beat already taken
  logic first_beat;

  assign first_beat = wqe_i.valid && !in_pkt;

  always_ff @(posedge core_clk or negedge core_aresetn) begin
    if (!core_aresetn) begin
      in_pkt      <= 1'b0;
      req_valid_o <= 1'b0;
    end else begin
      req_valid_o <= wqe_i.valid && wqe_i.last;
      if (wqe_i.valid && wqe_i.last) begin
        in_pkt <= 1'b0;
      end else if (first_beat) begin
        in_pkt <= 1'b1;
      end
    end
  end

  // lowest byte index is the most significant byte
  always_ff @(posedge core_clk) begin
    if (first_beat) begin
      req_o.qp_num <= {wqe_i.data[47*8 +: 8],
                       wqe_i.data[48*8 +: 8],
                       wqe_i.data[49*8 +: 8]};
      req_o.psn    <= {wqe_i.data[51*8 +: 8],
                       wqe_i.data[52*8 +: 8],
                       wqe_i.data[53*8 +: 8]};
    end
  end

endmodule

// File: source/resp_hdr_build.sv
module resp_hdr_build (
  input  logic                    core_clk,
  input  logic                    core_aresetn,
  input  roce_hdr_pkg::net_cfg_t  net_cfg_i,
  input  resp_ctrl_pkg::phase_e   phase_i,
  input  resp_ctrl_pkg::rd_req_t  req_i,
  input  logic                    req_valid_i,
  output roce_hdr_pkg::roce_hdr_t hdr_o,
  output logic                    hdr_valid_o
);

  logic [$clog2(roce_hdr_pkg::QP_COUNT)-1:0] qp_idx;
  roce_hdr_pkg::qp_route_t                   route;
  roce_hdr_pkg::bth_opcode_e                 opcode;
  logic [15:0]                               ip_total_len;
  logic [15:0]                               udp_len;
  logic [159:0]                              ip_words;
  logic [15:0]                               ip_csum;
  logic [roce_hdr_pkg::HDR_BYTES*8-1:0]      wire_img; // byte 0 in the top bits
  roce_hdr_pkg::roce_hdr_t                   hdr_next;

  // ones-complement sum over the ten IPv4 header words
  function automatic logic [15:0] ipv4_csum(input logic [159:0] words);
    logic [19:0] sum;
    int          w;
    sum = '0;
    for (w = 0; w < 10; w++) begin
      sum = sum + 20'(words[w*16 +: 16]);
    end
    sum = 20'(sum[15:0]) + 20'(sum[19:16]);
    sum = 20'(sum[15:0]) + 20'(sum[19:16]); // second fold catches the last carry
    return ~sum[15:0];
  endfunction

  // unknown QPs fall back to the QP 2 entry
  always_comb begin
    qp_idx = '0;
    if (req_i.qp_num >= 24'(roce_hdr_pkg::QP_FIRST) &&
        req_i.qp_num < 24'(roce_hdr_pkg::QP_FIRST + roce_hdr_pkg::QP_COUNT)) begin
      qp_idx = $bits(qp_idx)'(req_i.qp_num - 24'(roce_hdr_pkg::QP_FIRST));
    end
    route = net_cfg_i.route[qp_idx];
  end

  always_comb begin
    if (phase_i == resp_ctrl_pkg::PH_ACK) begin
      opcode       = roce_hdr_pkg::OP_ACK;
      ip_total_len = roce_hdr_pkg::IP_TOTAL_LEN_ACK;
      udp_len      = roce_hdr_pkg::UDP_LEN_ACK;
    end else begin
      opcode       = roce_hdr_pkg::OP_RD_RESP_ONLY;
      ip_total_len = roce_hdr_pkg::IP_TOTAL_LEN_RD;
      udp_len      = roce_hdr_pkg::UDP_LEN_RD;
    end
  end

  assign ip_words = {roce_hdr_pkg::IP_VER_IHL, roce_hdr_pkg::IP_TOS, ip_total_len,
                     roce_hdr_pkg::IP_ID, roce_hdr_pkg::IP_FLAGS,
                     roce_hdr_pkg::IP_TTL, roce_hdr_pkg::IP_PROTO_UDP,
                     16'h0000, net_cfg_i.src_ip, route.dst_ip};
  assign ip_csum  = ipv4_csum(ip_words);

  assign wire_img = {route.dst_mac, net_cfg_i.src_mac, roce_hdr_pkg::ETHERTYPE_IPV4,
                     ip_words[159:80], ip_csum, ip_words[63:0],
                     roce_hdr_pkg::UDP_SRC_PORT, roce_hdr_pkg::UDP_DST_PORT,
                     udp_len, 16'h0000,
                     opcode, 8'h00, roce_hdr_pkg::BTH_PKEY,
                     24'h050000,          // reserved and dest QP high bytes
                     req_i.qp_num[15:0], req_i.psn,
                     32'h0000_0000};      // AETH

  always_comb begin
    for (int b = 0; b < roce_hdr_pkg::HDR_BYTES; b++) begin
      hdr_next[b] = wire_img[(roce_hdr_pkg::HDR_BYTES-1-b)*8 +: 8];
    end
  end

  always_ff @(posedge core_clk or negedge core_aresetn) begin
    if (!core_aresetn) begin
      hdr_valid_o <= 1'b0;
    end else begin
      hdr_valid_o <= req_valid_i;
    end
  end

  always_ff @(posedge core_clk) begin
    if (req_valid_i) begin
      hdr_o <= hdr_next;
    end
  end

endmodule

// File: source/axis_beat_emit.sv
module axis_beat_emit (
  input  logic                    core_clk,
  input  logic                    core_aresetn,
  input  resp_ctrl_pkg::phase_e   phase_i,
  input  roce_hdr_pkg::roce_hdr_t hdr_i,
  input  logic                    hdr_valid_i,
  input  logic                    tx_ready_i,
  output resp_ctrl_pkg::tx_beat_t tx_beat_o,
  output logic                    pkt_sent_o
);

  roce_hdr_pkg::roce_hdr_t                             hdr_q;
  resp_ctrl_pkg::phase_e                               phase_q;
  logic                                                active;
  logic [roce_hdr_pkg::BEAT_IDX_W-1:0]                 beat_idx;
  logic [roce_hdr_pkg::LEN_W-1:0]                      remaining; // incl. beat on the bus
  logic [3:0]                                          seed;      // packet number in phase
  logic [7:0]                                          pay_byte;
  logic [roce_hdr_pkg::BEAT_BYTES-1:0][7:0]            first_beat;
  logic                                                accept;

  assign pay_byte   = {4'h1, seed};
  assign first_beat = {{(roce_hdr_pkg::BEAT_BYTES - roce_hdr_pkg::HDR_BYTES){pay_byte}}, hdr_q};
  assign accept     = active && tx_ready_i;

  always_comb begin
    tx_beat_o.valid = active;
    tx_beat_o.last  = active && (remaining <= roce_hdr_pkg::LEN_W'(roce_hdr_pkg::BEAT_BYTES));
    for (int l = 0; l < roce_hdr_pkg::BEAT_BYTES; l++) begin
      tx_beat_o.keep[l] = roce_hdr_pkg::LEN_W'(l) < remaining;
      if (!tx_beat_o.keep[l]) begin
        tx_beat_o.data[l*8 +: 8] = 8'h00;
      end else if (beat_idx == '0) begin
        tx_beat_o.data[l*8 +: 8] = first_beat[l];
      end else begin
        tx_beat_o.data[l*8 +: 8] = pay_byte;
      end
    end
  end

  always_ff @(posedge core_clk or negedge core_aresetn) begin
    if (!core_aresetn) begin
      active     <= 1'b0;
      beat_idx   <= '0;
      remaining  <= '0;
      seed       <= '0;
      phase_q    <= resp_ctrl_pkg::PH_IDLE;
      pkt_sent_o <= 1'b0;
    end else begin
      pkt_sent_o <= 1'b0;
      if (hdr_valid_i) begin
        active   <= 1'b1;
        beat_idx <= '0;
        phase_q  <= phase_i;
        seed     <= (phase_i == phase_q) ? seed + 4'd1 : 4'd1; // restart per phase
        if (phase_i == resp_ctrl_pkg::PH_ACK) begin
          remaining <= roce_hdr_pkg::LEN_W'(roce_hdr_pkg::HDR_BYTES);
        end else begin
          remaining <= roce_hdr_pkg::LEN_W'(roce_hdr_pkg::RD_RESP_BYTES);
        end
      end else if (accept) begin
        if (tx_beat_o.last) begin
          active     <= 1'b0;
          remaining  <= '0;
          pkt_sent_o <= 1'b1;
        end else begin
          remaining <= remaining - roce_hdr_pkg::LEN_W'(roce_hdr_pkg::BEAT_BYTES);
          beat_idx  <= beat_idx + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge core_clk) begin
    if (hdr_valid_i) begin
      hdr_q <= hdr_i;
    end
  end

endmodule

// File: source/resp_phase_seq.sv
module resp_phase_seq (
  input  logic                  core_clk,
  input  logic                  core_aresetn,
  input  logic                  conf_done_i,
  input  logic                  pkt_sent_i,
  output resp_ctrl_pkg::phase_e phase_o,
  output logic                  post_rd_req_o,
  output logic                  post_wr_req_o,
  output logic                  rd_phase_done_o,
  output logic                  wr_phase_done_o
);

  resp_ctrl_pkg::seq_state_e                state;
  logic [resp_ctrl_pkg::PKT_CNT_W-1:0]      pkt_cnt;
  logic [resp_ctrl_pkg::GAP_CNT_W-1:0]      gap_cnt;
  logic                                     gap_end;
  logic                                     phase_end;

  assign gap_end   = gap_cnt == resp_ctrl_pkg::GAP_CNT_W'(resp_ctrl_pkg::GAP_CYCLES - 1);
  assign phase_end = pkt_cnt == resp_ctrl_pkg::PKT_CNT_W'(resp_ctrl_pkg::NUM_PKTS_PER_PHASE);

  // S_POST lasts one cycle, so the posts are single pulses
  assign post_rd_req_o = (state == resp_ctrl_pkg::S_POST) && (phase_o == resp_ctrl_pkg::PH_RD_RESP);
  assign post_wr_req_o = (state == resp_ctrl_pkg::S_POST) && (phase_o == resp_ctrl_pkg::PH_ACK);

  assign rd_phase_done_o = (phase_o == resp_ctrl_pkg::PH_ACK) || (phase_o == resp_ctrl_pkg::PH_DONE);
  assign wr_phase_done_o = phase_o == resp_ctrl_pkg::PH_DONE;

  always_ff @(posedge core_clk or negedge core_aresetn) begin
    if (!core_aresetn) begin
      state   <= resp_ctrl_pkg::S_WAIT_CONF;
      phase_o <= resp_ctrl_pkg::PH_IDLE;
      pkt_cnt <= '0;
      gap_cnt <= '0;
    end else begin
      case (state)
        resp_ctrl_pkg::S_WAIT_CONF: begin
          if (conf_done_i && phase_o != resp_ctrl_pkg::PH_DONE) begin
            if (phase_o == resp_ctrl_pkg::PH_IDLE) begin
              phase_o <= resp_ctrl_pkg::PH_RD_RESP;
            end
            state <= resp_ctrl_pkg::S_POST;
          end
        end
        resp_ctrl_pkg::S_POST: state <= resp_ctrl_pkg::S_WAIT_REQ;
        resp_ctrl_pkg::S_WAIT_REQ: begin
          if (pkt_sent_i) begin // request answered and packet out
            state <= resp_ctrl_pkg::S_SEND;
          end
        end
        resp_ctrl_pkg::S_SEND: begin
          pkt_cnt <= pkt_cnt + 1'b1;
          gap_cnt <= '0;
          state   <= resp_ctrl_pkg::S_GAP;
        end
        resp_ctrl_pkg::S_GAP: begin
          gap_cnt <= gap_cnt + 1'b1;
          if (gap_end) begin
            if (phase_end) begin
              pkt_cnt <= '0;
              phase_o <= (phase_o == resp_ctrl_pkg::PH_RD_RESP) ? resp_ctrl_pkg::PH_ACK
                                                                : resp_ctrl_pkg::PH_DONE;
              state   <= resp_ctrl_pkg::S_WAIT_CONF;
            end else begin
              state <= resp_ctrl_pkg::S_POST;
            end
          end
        end
        default: state <= resp_ctrl_pkg::S_WAIT_CONF;
      endcase
    end
  end

endmodule

// File: source/rdma_resp_gen_top.sv
module rdma_resp_gen_top (
  input  logic                     core_clk,
  input  logic                     core_aresetn,
  input  roce_hdr_pkg::net_cfg_t   net_cfg_i,
  input  logic                     conf_done_i,
  input  resp_ctrl_pkg::wqe_beat_t wqe_i,
  input  logic                     tx_ready_i,
  output resp_ctrl_pkg::tx_beat_t  tx_beat_o,
  output logic                     post_rd_req_o,
  output logic                     post_wr_req_o,
  output logic                     rd_phase_done_o,
  output logic                     wr_phase_done_o
);

  resp_ctrl_pkg::rd_req_t  req;
  logic                    req_valid;
  roce_hdr_pkg::roce_hdr_t hdr;
  logic                    hdr_valid;
  logic                    pkt_sent;
  resp_ctrl_pkg::phase_e   phase;

  wqe_req_decode u_decode (
    .core_clk    (core_clk),
    .core_aresetn(core_aresetn),
    .wqe_i       (wqe_i),
    .req_o       (req),
    .req_valid_o (req_valid)
  );

  resp_hdr_build u_hdr (
    .core_clk    (core_clk),
    .core_aresetn(core_aresetn),
    .net_cfg_i   (net_cfg_i),
    .phase_i     (phase),
    .req_i       (req),
    .req_valid_i (req_valid),
    .hdr_o       (hdr),
    .hdr_valid_o (hdr_valid)
  );

  axis_beat_emit u_emit (
    .core_clk    (core_clk),
    .core_aresetn(core_aresetn),
    .phase_i     (phase),
    .hdr_i       (hdr),
    .hdr_valid_i (hdr_valid),
    .tx_ready_i  (tx_ready_i),
    .tx_beat_o   (tx_beat_o),
    .pkt_sent_o  (pkt_sent)
  );

  resp_phase_seq u_seq (
    .core_clk       (core_clk),
    .core_aresetn   (core_aresetn),
    .conf_done_i    (conf_done_i),
    .pkt_sent_i     (pkt_sent),
    .phase_o        (phase),
    .post_rd_req_o  (post_rd_req_o),
    .post_wr_req_o  (post_wr_req_o),
    .rd_phase_done_o(rd_phase_done_o),
    .wr_phase_done_o(wr_phase_done_o)
  );

endmodule

// File: verif/resp_gen_props.sv
module resp_gen_props (
  input logic                    core_clk,
  input logic                    core_aresetn,
  input resp_ctrl_pkg::tx_beat_t tx_beat_i,
  input logic                    tx_ready_i,
  input logic                    post_rd_req_i,
  input logic                    post_wr_req_i
);

  // a stalled beat holds until it is taken
  beat_held: assert property (@(posedge core_clk) disable iff (!core_aresetn)
    tx_beat_i.valid && !tx_ready_i |=> tx_beat_i.valid && $stable(tx_beat_i.data) &&
      $stable(tx_beat_i.keep) && $stable(tx_beat_i.last))
    else $error("tx beat changed while stalled");

  rd_post_pulse: assert property (@(posedge core_clk) disable iff (!core_aresetn)
    post_rd_req_i |=> !post_rd_req_i)
    else $error("read post longer than one cycle");

  wr_post_pulse: assert property (@(posedge core_clk) disable iff (!core_aresetn)
    post_wr_req_i |=> !post_wr_req_i)
    else $error("write post longer than one cycle");

endmodule

bind rdma_resp_gen_top resp_gen_props u_props (
  .core_clk     (core_clk),
  .core_aresetn (core_aresetn),
  .tx_beat_i    (tx_beat_o),
  .tx_ready_i   (tx_ready_i),
  .post_rd_req_i(post_rd_req_o),
  .post_wr_req_i(post_wr_req_o)
);

// File: verif/resp_gen_checker.sv
module resp_gen_checker (
  input  logic                    core_clk,
  input  logic                    core_aresetn,
  input  roce_hdr_pkg::net_cfg_t  net_cfg_i,
  input  logic                    conf_done_i,
  input  resp_ctrl_pkg::tx_beat_t tx_beat_i,
  input  logic                    tx_ready_i,
  input  logic                    post_rd_req_i,
  input  logic                    post_wr_req_i,
  input  logic                    rd_phase_done_i,
  input  logic                    wr_phase_done_i,
  input  logic                    req_sent_i,
  input  resp_ctrl_pkg::rd_req_t  req_sent_data_i,
  output int                      data_errors_o,
  output int                      order_errors_o,
  output int                      pkts_checked_o
);

  logic [7:0]              exp_bytes [0:319]; // five beats max
  int                      exp_len;
  resp_ctrl_pkg::rd_req_t  req_q [$];
  int                      beat_idx;
  int                      rd_posts;
  int                      wr_posts;
  int                      lane;
  logic [511:0]            exp_data;
  logic [511:0]            lane_mask;
  logic [63:0]             exp_keep;
  logic                    exp_last;
  logic                    stalled;
  logic                    prev_post;
  logic                    rd_done_q;
  logic                    wr_done_q;
  resp_ctrl_pkg::tx_beat_t held;
  string                   kind;

  task automatic order_fail(input string what);
    $display("%s", what);
    order_errors_o++;
  endtask

  task automatic check_field(input string field, input logic [511:0] exp,
                             input logic [511:0] act);
    if (exp !== act) begin
      $display("error %s pkt %0d beat %0d %s: expected %0h actual %0h",
               kind, pkts_checked_o + 1, beat_idx, field, exp, act);
      data_errors_o++;
    end
  endtask

  // big endian starting at byte pos
  task automatic put_bytes(input int pos, input logic [79:0] val, input int nbytes);
    int k;
    for (k = 0; k < nbytes; k++) begin
      exp_bytes[pos + k] = val[(nbytes - 1 - k)*8 +: 8];
    end
  endtask

  task automatic build_expected(input resp_ctrl_pkg::rd_req_t req, input bit ack, input int n);
    roce_hdr_pkg::qp_route_t rt;
    logic [15:0]             tot_len;
    logic [159:0]            ip_hdr;
    logic [31:0]             sum;
    int                      w;
    rt = net_cfg_i.route[0]; // QPs outside the table use the QP 2 entry
    if (req.qp_num >= 2 && req.qp_num <= 7) begin
      rt = net_cfg_i.route[req.qp_num - 2];
    end
    tot_len = ack ? 16'h0030 : 16'h0130;
    exp_len = ack ? 58 : 314;
    ip_hdr  = {8'h45, 8'hb8, tot_len, 16'h5555, 16'h4000, 8'hba, 8'h11, 16'h0000,
               net_cfg_i.src_ip, rt.dst_ip};
    sum = 0;
    for (w = 0; w < 10; w++) begin
      sum = sum + ip_hdr[w*16 +: 16];
    end
    while (sum > 32'hffff) begin
      sum = (sum & 32'hffff) + (sum >> 16);
    end
    for (w = 0; w < 320; w++) begin
      exp_bytes[w] = 8'h10 + 8'(n);
    end
    put_bytes(0, rt.dst_mac, 6);
    put_bytes(6, net_cfg_i.src_mac, 6);
    put_bytes(12, 16'h0800, 2);
    put_bytes(14, ip_hdr[159:80], 10);
    put_bytes(24, ~sum[15:0], 2);
    put_bytes(26, ip_hdr[63:0], 8);
    put_bytes(34, {16'h6851, 16'h12b7, tot_len - 16'd20, 16'h0000}, 8);
    put_bytes(42, {ack ? 8'h11 : 8'h10, 8'h00, 16'h666f, 24'h050000, req.qp_num[15:0]}, 9);
    put_bytes(51, {req.psn, 32'h0000_0000}, 7); // psn followed by the zero AETH
  endtask

  task automatic check_beat();
    if (beat_idx == 0) begin
      kind = (pkts_checked_o < resp_ctrl_pkg::NUM_PKTS_PER_PHASE) ? "read_resp" : "ack";
      if (req_q.size() == 0) begin
        order_fail("packet started without a request from the responder");
        exp_len = 0;
      end else begin
        build_expected(req_q.pop_front(), pkts_checked_o >= resp_ctrl_pkg::NUM_PKTS_PER_PHASE,
                       pkts_checked_o % resp_ctrl_pkg::NUM_PKTS_PER_PHASE + 1);
      end
    end
    for (lane = 0; lane < 64; lane++) begin
      exp_keep[lane]          = beat_idx*64 + lane < exp_len;
      exp_data[lane*8 +: 8]   = exp_keep[lane] ? exp_bytes[beat_idx*64 + lane] : 8'h00;
      lane_mask[lane*8 +: 8]  = {8{exp_keep[lane]}};
    end
    exp_last = (beat_idx + 1) * 64 >= exp_len;
    check_field("keep", 512'(exp_keep), 512'(tx_beat_i.keep));
    check_field("last", 512'(exp_last), 512'(tx_beat_i.last));
    check_field("data", exp_data, tx_beat_i.data & lane_mask);
    if (tx_beat_i.last) begin
      beat_idx = 0;
      pkts_checked_o++;
    end else begin
      beat_idx++;
    end
  endtask

  always @(posedge core_clk or negedge core_aresetn) begin
    if (!core_aresetn) begin
      data_errors_o  = 0;
      order_errors_o = 0;
      pkts_checked_o = 0;
      beat_idx       = 0;
      rd_posts       = 0;
      wr_posts       = 0;
      stalled        = 1'b0;
      prev_post      = 1'b0;
      rd_done_q      = 1'b0;
      wr_done_q      = 1'b0;
      req_q.delete();
    end else begin
      if (req_sent_i) begin
        req_q.push_back(req_sent_data_i);
      end
      if (stalled && tx_beat_i !== held) begin
        $display("beat changed or vanished while tx_ready was low");
        data_errors_o++;
      end
      stalled = tx_beat_i.valid && !tx_ready_i;
      held    = tx_beat_i;
      if (tx_beat_i.valid && tx_ready_i) begin
        check_beat();
      end
      if ((post_rd_req_i || post_wr_req_i) && prev_post) begin
        order_fail("post pulse lasted more than one cycle");
      end
      prev_post = post_rd_req_i || post_wr_req_i;
      if (post_rd_req_i) begin
        if (!conf_done_i || rd_phase_done_i || rd_posts >= 8) begin
          order_fail("read post came out of order");
        end
        rd_posts++;
      end
      if (post_wr_req_i) begin
        if (!rd_phase_done_i || wr_phase_done_i || wr_posts >= 8) begin
          order_fail("write post came out of order");
        end
        wr_posts++;
      end
      if (rd_phase_done_i && !rd_done_q && (rd_posts != 8 || pkts_checked_o != 8)) begin
        order_fail("read phase done rose before eight read packets");
      end
      if (wr_phase_done_i && !wr_done_q &&
          (!rd_phase_done_i || wr_posts != 8 || pkts_checked_o != 16)) begin
        order_fail("write phase done rose before eight ACK packets");
      end
      if ((rd_done_q && !rd_phase_done_i) || (wr_done_q && !wr_phase_done_i)) begin
        order_fail("a phase done level dropped");
      end
      rd_done_q = rd_phase_done_i;
      wr_done_q = wr_phase_done_i;
    end
  end

endmodule

// File: verif/tb_rdma_resp_gen.sv
module tb_rdma_resp_gen;

  logic                     core_clk;
  logic                     core_aresetn;
  roce_hdr_pkg::net_cfg_t   net_cfg;
  logic                     conf_done;
  resp_ctrl_pkg::wqe_beat_t wqe;
  logic                     tx_ready;
  resp_ctrl_pkg::tx_beat_t  tx_beat;
  logic                     post_rd_req;
  logic                     post_wr_req;
  logic                     rd_phase_done;
  logic                     wr_phase_done;
  logic                     req_sent;
  resp_ctrl_pkg::rd_req_t   req_sent_data;
  int                       data_errors;
  int                       order_errors;
  int                       pkts_checked;
  int                       run_errors;
  logic [31:0]              rng_state;
  logic [575:0]             cfg_bits;
  int                       resp_delay;
  int                       resp_beats;
  int                       reqs_sent;
  int                       cyc;
  int                       done_at;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // work-request processor model sending two beats per post
  task automatic step_responder();
    resp_ctrl_pkg::rd_req_t req;
    logic [31:0]            r;
    int                     w;
    wqe.valid = 1'b0;
    wqe.last  = 1'b0;
    req_sent  = 1'b0;
    if (post_rd_req || post_wr_req) begin
      resp_delay = 1 + int'(next_rand() % 20);
      resp_beats = 2;
    end else if (resp_delay > 0) begin
      resp_delay--;
    end else if (resp_beats > 0) begin
      for (w = 0; w < 16; w++) begin
        wqe.data[w*32 +: 32] = next_rand();
      end
      if (resp_beats == 2) begin
        r          = next_rand();
        req.qp_num = 24'(2 + r % 7); // 8 is outside the route table
        if (reqs_sent % resp_ctrl_pkg::NUM_PKTS_PER_PHASE == 0) begin
          req.qp_num = 24'd8; // first request of each phase takes the fallback route
        end
        r          = next_rand();
        req.psn    = r[23:0];
        for (w = 0; w < 3; w++) begin
          wqe.data[(47 + w)*8 +: 8] = req.qp_num[(2 - w)*8 +: 8];
          wqe.data[(51 + w)*8 +: 8] = req.psn[(2 - w)*8 +: 8];
        end
        req_sent      = 1'b1;
        req_sent_data = req;
        reqs_sent++;
      end
      wqe.valid = 1'b1;
      wqe.last  = resp_beats == 1;
      resp_beats--;
    end
  endtask

  initial begin
    core_clk = 1'b0;
    forever #50 core_clk = ~core_clk;
  end

  rdma_resp_gen_top dut (
    .core_clk       (core_clk),
    .core_aresetn   (core_aresetn),
    .net_cfg_i      (net_cfg),
    .conf_done_i    (conf_done),
    .wqe_i          (wqe),
    .tx_ready_i     (tx_ready),
    .tx_beat_o      (tx_beat),
    .post_rd_req_o  (post_rd_req),
    .post_wr_req_o  (post_wr_req),
    .rd_phase_done_o(rd_phase_done),
    .wr_phase_done_o(wr_phase_done)
  );

  resp_gen_checker u_checker (
    .core_clk       (core_clk),
    .core_aresetn   (core_aresetn),
    .net_cfg_i      (net_cfg),
    .conf_done_i    (conf_done),
    .tx_beat_i      (tx_beat),
    .tx_ready_i     (tx_ready),
    .post_rd_req_i  (post_rd_req),
    .post_wr_req_i  (post_wr_req),
    .rd_phase_done_i(rd_phase_done),
    .wr_phase_done_i(wr_phase_done),
    .req_sent_i     (req_sent),
    .req_sent_data_i(req_sent_data),
    .data_errors_o  (data_errors),
    .order_errors_o (order_errors),
    .pkts_checked_o (pkts_checked)
  );

  initial begin
    core_aresetn  = 1'b0;
    conf_done     = 1'b0;
    wqe           = '0;
    tx_ready      = 1'b0;
    req_sent      = 1'b0;
    req_sent_data = '0;
    rng_state     = 32'd93015;
    run_errors    = 0;
    resp_delay    = 0;
    resp_beats    = 0;
    reqs_sent     = 0;
    done_at       = -1;
    for (int w = 0; w < 18; w++) begin
      cfg_bits[w*32 +: 32] = next_rand();
    end
    net_cfg = cfg_bits[$bits(roce_hdr_pkg::net_cfg_t)-1:0];
    repeat (16) @(negedge core_clk);
    if (tx_beat.valid || post_rd_req || post_wr_req || rd_phase_done || wr_phase_done) begin
      $display("outputs were not idle during reset");
      run_errors++;
    end
    core_aresetn = 1'b1;
    repeat (3 + next_rand() % 8) @(negedge core_clk);
    conf_done = 1'b1;
    cyc       = 0;
    // run until both phases finish and watch the done levels a while longer
    while (cyc < 20000 && (done_at < 0 || cyc - done_at < 300)) begin
      @(negedge core_clk);
      tx_ready = (next_rand() % 10) >= 3;
      step_responder();
      if (wr_phase_done && done_at < 0) begin
        done_at = cyc;
      end
      cyc++;
    end
    if (done_at < 0) begin
      $display("timeout: the write phase never finished");
      run_errors++;
    end
    if (pkts_checked != 2 * resp_ctrl_pkg::NUM_PKTS_PER_PHASE) begin
      $display("only %0d of 16 packets arrived", pkts_checked);
      run_errors++;
    end
    $display("errors: data %0d, order %0d, run %0d", data_errors, order_errors, run_errors);
    if (data_errors + order_errors + run_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: rdma_resp_gen.f
source/roce_hdr_pkg.sv
source/resp_ctrl_pkg.sv
source/wqe_req_decode.sv
source/resp_hdr_build.sv
source/axis_beat_emit.sv
source/resp_phase_seq.sv
source/rdma_resp_gen_top.sv
verif/resp_gen_props.sv
verif/resp_gen_checker.sv
verif/tb_rdma_resp_gen.sv

// File: Bender.yml
package:
  name: rdma_resp_gen

sources:
  - source/roce_hdr_pkg.sv
  - source/resp_ctrl_pkg.sv
  - source/wqe_req_decode.sv
  - source/resp_hdr_build.sv
  - source/axis_beat_emit.sv
  - source/resp_phase_seq.sv
  - source/rdma_resp_gen_top.sv
  - target: simulation
    files:
      - verif/resp_gen_props.sv
      - verif/resp_gen_checker.sv
      - verif/tb_rdma_resp_gen.sv
